//--- logic/es_data_pkg.sv
// Data widths for the entropy source
// Noise bus width, output word width and symbols per word
// Output word union with plain and per-symbol views

package es_data_pkg;

  // Raw noise bus from the analog source
  parameter int RngBusWidth = 4;

  // Entropy word handed to the consumer
  parameter int EntropyWidth = 32;

  // Noise samples that make up one word
  parameter int SymbolsPerWord = EntropyWidth / RngBusWidth;

  // One output word, seen whole or as noise symbols
  // Symbol 0 sits in the lowest nibble
  typedef union packed {
    logic [EntropyWidth-1:0]                     word;
    logic [SymbolsPerWord-1:0][RngBusWidth-1:0] symbols;
  } es_word_u;

endpackage

//--- logic/es_ctrl_pkg.sv
// Control definitions for the entropy source
// Main state machine encoding

package es_ctrl_pkg;

  // Main FSM states
  //   IDLE     module disabled, test state held clear
  //   STARTUP  first health window, nothing is emitted
  //   CONT     continuous operation, words are packed
  //   HALTED   a health test tripped, wait for disable
  typedef enum logic [1:0] {
    IDLE    = 2'b00,
    STARTUP = 2'b01,
    CONT    = 2'b10,
    HALTED  = 2'b11
  } es_state_e;

endpackage

//--- logic/es_main_fsm.sv
// Main FSM of the entropy source
// Sequences idle, startup, continuous and halted operation
// Holds the sticky health failure and the recoverable alert pulse

module es_main_fsm (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic es_enable_i,
  input  logic window_end_i,
  input  logic fail_i,
  output logic test_clr_o,
  output logic tests_run_o,
  output logic pack_run_o,
  output logic health_fail_o,
  output logic recov_alert_o,
  output logic es_idle_o
);

  es_ctrl_pkg::es_state_e state_q;
  es_ctrl_pkg::es_state_e state_d;
  logic                   trip;

  // Failure only counts while tests are live and the module is on
  assign trip = fail_i && es_enable_i &&
                (state_q == es_ctrl_pkg::STARTUP || state_q == es_ctrl_pkg::CONT);

  always_comb begin
    state_d = state_q;
    if (!es_enable_i) begin
      state_d = es_ctrl_pkg::IDLE;
    end else begin
      case (state_q)
        es_ctrl_pkg::IDLE:    state_d = es_ctrl_pkg::STARTUP;
        es_ctrl_pkg::STARTUP: begin
          // Failure wins over a clean window close
          if (fail_i) begin
            state_d = es_ctrl_pkg::HALTED;
          end else if (window_end_i) begin
            state_d = es_ctrl_pkg::CONT;
          end
        end
        es_ctrl_pkg::CONT: begin
          if (fail_i) begin
            state_d = es_ctrl_pkg::HALTED;
          end
        end
        es_ctrl_pkg::HALTED:  state_d = es_ctrl_pkg::HALTED;
        default:              state_d = es_ctrl_pkg::IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q       <= es_ctrl_pkg::IDLE;
      health_fail_o <= 1'b0;
      recov_alert_o <= 1'b0;
    end else begin
      state_q       <= state_d;
      recov_alert_o <= trip;
      if (!es_enable_i) begin
        health_fail_o <= 1'b0;
      end else if (trip) begin
        health_fail_o <= 1'b1;
      end
    end
  end

  // Control levels
  assign test_clr_o  = (state_q == es_ctrl_pkg::IDLE);
  assign tests_run_o = (state_q == es_ctrl_pkg::STARTUP) || (state_q == es_ctrl_pkg::CONT);
  assign pack_run_o  = (state_q == es_ctrl_pkg::CONT);
  assign es_idle_o   = (state_q == es_ctrl_pkg::IDLE);

  //////////////////////////////////////////////////////////////////////////
  // Assertions
  //////////////////////////////////////////////////////////////////////////

  // Packing starts only after a clean startup window
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(pack_run_o) |-> $past(window_end_i && !fail_i));

  // One alert per failure event
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    recov_alert_o |=> !recov_alert_o);

endmodule

//--- logic/es_window_timer.sv
// Health test window timer
// Counts accepted samples, pulses at each window close

module es_window_timer #(
  parameter int WindowSize = 32
) (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic clr_i,
  input  logic run_i,
  input  logic rng_valid_i,
  output logic window_end_o
);

  localparam int              CntW    = $clog2(WindowSize + 1);
  localparam logic [CntW-1:0] LastCnt = CntW'(WindowSize - 1);
  localparam logic [CntW-1:0] MaxCnt  = CntW'(WindowSize);

  logic [CntW-1:0] win_cnt_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i || clr_i) begin
      win_cnt_q    <= '0;
      window_end_o <= 1'b0;
    end else begin
      window_end_o <= 1'b0;
      if (run_i && rng_valid_i) begin
        if (win_cnt_q == LastCnt) begin
          win_cnt_q    <= '0;
          window_end_o <= 1'b1;
        end else begin
          win_cnt_q <= win_cnt_q + CntW'(1);
        end
      end
    end
  end

  // Wrap happens one short of the window size
  assert property (@(posedge clk_i) disable iff (!rst_n_i) win_cnt_q < MaxCnt);

endmodule

//--- logic/es_health_tests.sv
// Health tests on the raw noise bus
// Per-lane repetition count test
// Per-lane adaptive proportion test over one window

module es_health_tests #(
  parameter int WindowSize   = 32,
  parameter int RepCntThresh = 8,
  parameter int AdaptHi      = 24,
  parameter int AdaptLo      = 8
) (
  input  logic                                 clk_i,
  input  logic                                 rst_n_i,
  input  logic                                 clr_i,
  input  logic                                 run_i,
  input  logic                                 rng_valid_i,
  input  logic [es_data_pkg::RngBusWidth-1:0] rng_bits_i,
  input  logic                                 window_end_i,
  output logic                                 fail_o
);

  localparam int Lanes = es_data_pkg::RngBusWidth;
  localparam int RepW  = $clog2(RepCntThresh + 1);
  localparam int OnesW = $clog2(WindowSize + 1);

  localparam logic [RepW-1:0]  RepMax = RepW'(RepCntThresh);
  localparam logic [OnesW-1:0] HiCnt  = OnesW'(AdaptHi);
  localparam logic [OnesW-1:0] LoCnt  = OnesW'(AdaptLo);

  logic             sample;
  logic [Lanes-1:0] rep_hit;
  logic [Lanes-1:0] adapt_hit;
  logic             rep_fail_q;

  assign sample = run_i && rng_valid_i;

  for (genvar l = 0; l < Lanes; l++) begin : gen_lane
    logic             prev_q;
    logic [RepW-1:0]  rep_cnt_q;
    logic [RepW-1:0]  rep_cnt_d;
    logic [OnesW-1:0] ones_q;

    ////////////////////////////////////////////////////////////////////////
    // Repetition count
    ////////////////////////////////////////////////////////////////////////

    // Run length saturates at the threshold
    always_comb begin
      if (rep_cnt_q != '0 && rng_bits_i[l] == prev_q) begin
        rep_cnt_d = (rep_cnt_q == RepMax) ? rep_cnt_q : rep_cnt_q + RepW'(1);
      end else begin
        rep_cnt_d = RepW'(1);
      end
    end

    assign rep_hit[l] = sample && (rep_cnt_d == RepMax) && (rep_cnt_q != RepMax);

    ////////////////////////////////////////////////////////////////////////
    // Adaptive proportion
    ////////////////////////////////////////////////////////////////////////

    // Count already holds the closing sample when window_end_i arrives
    assign adapt_hit[l] = window_end_i && (ones_q > HiCnt || ones_q < LoCnt);

    always_ff @(posedge clk_i) begin
      if (!rst_n_i || clr_i) begin
        prev_q    <= 1'b0;
        rep_cnt_q <= '0;
        ones_q    <= '0;
      end else begin
        if (sample) begin
          prev_q    <= rng_bits_i[l];
          rep_cnt_q <= rep_cnt_d;
        end
        // New window may start with a sample in the same cycle
        if (window_end_i) begin
          ones_q <= sample ? OnesW'(rng_bits_i[l]) : '0;
        end else if (sample) begin
          ones_q <= ones_q + OnesW'(rng_bits_i[l]);
        end
      end
    end

    assert property (@(posedge clk_i) disable iff (!rst_n_i) rep_cnt_q <= RepMax);
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i || clr_i) begin
      rep_fail_q <= 1'b0;
    end else begin
      rep_fail_q <= |rep_hit;
    end
  end

  assign fail_o = rep_fail_q || (|adapt_hit);

endmodule

//--- logic/es_packer.sv
// Entropy word packer
// Collects accepted noise samples into 32-bit words

module es_packer (
  input  logic                                 clk_i,
  input  logic                                 rst_n_i,
  input  logic                                 run_i,
  input  logic                                 rng_valid_i,
  input  logic [es_data_pkg::RngBusWidth-1:0] rng_bits_i,
  output es_data_pkg::es_word_u                entropy_o,
  output logic                                 entropy_valid_o
);

  localparam int              IdxW    = $clog2(es_data_pkg::SymbolsPerWord);
  localparam logic [IdxW-1:0] LastIdx = IdxW'(es_data_pkg::SymbolsPerWord - 1);

  logic                  take;
  logic                  word_done;
  logic [IdxW-1:0]       idx_q;
  es_data_pkg::es_word_u part_q;
  es_data_pkg::es_word_u part_d;

  assign take      = run_i && rng_valid_i;
  assign word_done = take && (idx_q == LastIdx);

  // Drop the new sample into its slot
  always_comb begin
    part_d                = part_q;
    part_d.symbols[idx_q] = rng_bits_i;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      idx_q           <= '0;
      entropy_valid_o <= 1'b0;
    end else begin
      entropy_valid_o <= word_done;
      if (!run_i) begin
        idx_q <= '0;
      end else if (take) begin
        idx_q <= (idx_q == LastIdx) ? '0 : idx_q + IdxW'(1);
      end
    end
  end

  // Partial word is discarded whenever packing stops
  always_ff @(posedge clk_i) begin
    if (!run_i) begin
      part_q <= '0;
    end else if (take) begin
      part_q <= part_d;
    end
    if (word_done) begin
      entropy_o <= part_d;
    end
  end

endmodule

//--- logic/entropy_src_top.sv
// Entropy source top level
// Health test thresholds and window size
// FSM, window timer, health tests and packer

module entropy_src_top #(
  parameter int WindowSize   = 32,
  parameter int RepCntThresh = 8,
  parameter int AdaptHi      = 24,
  parameter int AdaptLo      = 8
) (
  input  logic                                  clk_i,
  input  logic                                  rst_n_i,
  input  logic                                  es_enable_i,
  input  logic                                  rng_valid_i,
  input  logic [es_data_pkg::RngBusWidth-1:0]  rng_bits_i,
  output logic [es_data_pkg::EntropyWidth-1:0] entropy_o,
  output logic                                  entropy_valid_o,
  output logic                                  health_fail_o,
  output logic                                  recov_alert_o,
  output logic                                  es_idle_o
);

  logic                  test_clr;
  logic                  tests_run;
  logic                  pack_run;
  logic                  window_end;
  logic                  fail;
  es_data_pkg::es_word_u entropy_word;

  assign entropy_o = entropy_word.word;

  es_main_fsm u_main_fsm (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .es_enable_i   (es_enable_i),
    .window_end_i  (window_end),
    .fail_i        (fail),
    .test_clr_o    (test_clr),
    .tests_run_o   (tests_run),
    .pack_run_o    (pack_run),
    .health_fail_o (health_fail_o),
    .recov_alert_o (recov_alert_o),
    .es_idle_o     (es_idle_o)
  );

  es_window_timer #(
    .WindowSize (WindowSize)
  ) u_window_timer (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .clr_i        (test_clr),
    .run_i        (tests_run),
    .rng_valid_i  (rng_valid_i),
    .window_end_o (window_end)
  );

  es_health_tests #(
    .WindowSize   (WindowSize),
    .RepCntThresh (RepCntThresh),
    .AdaptHi      (AdaptHi),
    .AdaptLo      (AdaptLo)
  ) u_health_tests (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .clr_i        (test_clr),
    .run_i        (tests_run),
    .rng_valid_i  (rng_valid_i),
    .rng_bits_i   (rng_bits_i),
    .window_end_i (window_end),
    .fail_o       (fail)
  );

  es_packer u_packer (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .run_i           (pack_run),
    .rng_valid_i     (rng_valid_i),
    .rng_bits_i      (rng_bits_i),
    .entropy_o       (entropy_word),
    .entropy_valid_o (entropy_valid_o)
  );

endmodule

//--- tb/es_clk_gen.sv
// Testbench clock and reset source
// 10 ns clock, active low reset released on a falling edge

module es_clk_gen #(
  parameter int ResetCycles = 16
) (
  output logic clk_o,
  output logic rst_n_o
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  initial begin
    rst_n_o = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

//--- tb/tb_entropy_src.sv
// Testbench for the entropy source
// Stimulus table, cycle reference model, checks and watchdog

module tb_entropy_src;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int WindowSize   = 32;
  localparam int RepCntThresh = 8;
  localparam int AdaptHi      = 24;
  localparam int AdaptLo      = 8;
  localparam int Lanes        = es_data_pkg::RngBusWidth;
  localparam int ResetCycles  = 16;
  localparam int MarginCycles = 200;

  // Pattern kinds
  localparam int KRandom = 0;
  localparam int KConst  = 1;
  localparam int KBiasHi = 2;
  localparam int KBiasLo = 3;
  localparam int KAlt    = 4;

  localparam int NumRows = 11;
  // enable, samples, pattern, strobe gap
  localparam int Stim [NumRows][4] = '{
    '{1, 72, KRandom, 0}, '{1, 48, KRandom, 2}, '{1, 20, KConst, 1},
    '{0, 6, KRandom, 0},  '{1, 80, KAlt, 0},    '{1, 72, KBiasHi, 0},
    '{0, 4, KRandom, 0},  '{1, 72, KBiasLo, 1}, '{0, 4, KRandom, 0},
    '{1, 72, KRandom, 3}, '{0, 4, KRandom, 0}
  };

  logic clk_i, rst_n_i, es_enable_i, rng_valid_i;
  logic [Lanes-1:0] rng_bits_i;
  logic [es_data_pkg::EntropyWidth-1:0] entropy_o;
  logic entropy_valid_o, health_fail_o, recov_alert_o, es_idle_o;

  integer seed = 32'h3e09_a5e7;
  int     errors = 0;
  int     checks = 0;

  // Reference model state and the outputs it predicts for the next cycle
  es_ctrl_pkg::es_state_e m_state = es_ctrl_pkg::IDLE;
  bit          m_wend, m_fail, exp_valid, exp_fail, exp_alert;
  bit          exp_idle = 1'b1;
  bit          m_prev [Lanes];
  int          m_run [Lanes];
  int          m_ones [Lanes];
  int          m_win, m_idx;
  logic [31:0] m_part = '0;
  logic [31:0] exp_word = '0;
  // Run tracking for the stimulus generator
  bit          gen_prev [Lanes];
  int          gen_run [Lanes];

  es_clk_gen #(.ResetCycles(ResetCycles)) u_clk_gen (.clk_o(clk_i), .rst_n_o(rst_n_i));

  entropy_src_top #(
    .WindowSize(WindowSize), .RepCntThresh(RepCntThresh), .AdaptHi(AdaptHi), .AdaptLo(AdaptLo)
  ) dut_i (.*);

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic make_sample(input int kind, input int i, output logic [Lanes-1:0] bits);
    logic [Lanes-1:0] alt;
    alt  = i[0] ? 4'b1010 : 4'b0101;
    bits = Lanes'($random(seed));
    // Random lanes flip after four equal bits
    for (int l = 0; l < Lanes; l++) begin
      if (gen_run[l] >= 4 && bits[l] == gen_prev[l]) bits[l] = ~bits[l];
    end
    case (kind)
      KConst:  bits[0] = 1'b1;
      KBiasHi: bits = {alt[3], i % 8 != 7, alt[1:0]};
      KBiasLo: bits = {alt[3], i % 8 == 7, alt[1:0]};
      KAlt:    bits = alt;
      default: ;
    endcase
    for (int l = 0; l < Lanes; l++) begin
      gen_run[l]  = (bits[l] == gen_prev[l]) ? gen_run[l] + 1 : 1;
      gen_prev[l] = bits[l];
    end
  endtask

  task automatic predict_cycle(input bit en, input bit v, input logic [Lanes-1:0] bits);
    es_ctrl_pkg::es_state_e nxt;
    bit active;
    bit closed;
    bit hit;
    int n;
    active = (m_state == es_ctrl_pkg::STARTUP) || (m_state == es_ctrl_pkg::CONT);
    closed = 1'b0;
    hit    = 1'b0;
    // State moves on the window and fail events of the previous sample
    if (!en) begin
      nxt = es_ctrl_pkg::IDLE;
    end else begin
      case (m_state)
        es_ctrl_pkg::IDLE:    nxt = es_ctrl_pkg::STARTUP;
        es_ctrl_pkg::STARTUP: nxt = m_fail ? es_ctrl_pkg::HALTED :
                                    m_wend ? es_ctrl_pkg::CONT : es_ctrl_pkg::STARTUP;
        es_ctrl_pkg::CONT:    nxt = m_fail ? es_ctrl_pkg::HALTED : es_ctrl_pkg::CONT;
        default:              nxt = es_ctrl_pkg::HALTED;
      endcase
    end
    exp_alert = m_fail && en && active;
    exp_fail  = en && (exp_fail || exp_alert);
    exp_idle  = (nxt == es_ctrl_pkg::IDLE);

    ////////////////////////////////////////////////////////////////////////////
    // Health tests
    ////////////////////////////////////////////////////////////////////////////
    if (m_state == es_ctrl_pkg::IDLE) begin
      m_win = 0;
      for (int l = 0; l < Lanes; l++) begin
        m_prev[l] = 1'b0;
        m_run[l]  = 0;
        m_ones[l] = 0;
      end
    end else if (v && active) begin
      m_win++;
      closed = (m_win == WindowSize);
      for (int l = 0; l < Lanes; l++) begin
        n         = (m_run[l] != 0 && bits[l] == m_prev[l]) ? m_run[l] + 1 : 1;
        hit       = hit || (n == RepCntThresh);
        m_run[l]  = (n > RepCntThresh) ? RepCntThresh : n;
        m_prev[l] = bits[l];
        m_ones[l] = m_ones[l] + int'(bits[l]);
        if (closed) begin
          hit       = hit || m_ones[l] > AdaptHi || m_ones[l] < AdaptLo;
          m_ones[l] = 0;
        end
      end
      if (closed) m_win = 0;
    end
    m_wend = closed;
    m_fail = hit;

    // Packing, first sample in the lowest nibble
    exp_valid = 1'b0;
    if (m_state != es_ctrl_pkg::CONT) begin
      m_idx  = 0;
      m_part = '0;
    end else if (v) begin
      m_part[m_idx*Lanes +: Lanes] = bits;
      if (m_idx == es_data_pkg::SymbolsPerWord - 1) begin
        exp_valid = 1'b1;
        exp_word  = m_part;
        m_idx     = 0;
      end else begin
        m_idx++;
      end
    end
    m_state = nxt;
  endtask

  task automatic drive_cycle(input bit en, input bit v, input logic [Lanes-1:0] bits);
    @(negedge clk_i);
    check_value("entropy_valid_o", 32'(entropy_valid_o), 32'(exp_valid));
    if (exp_valid) check_value("entropy_o", entropy_o, exp_word);
    check_value("health_fail_o", 32'(health_fail_o), 32'(exp_fail));
    check_value("recov_alert_o", 32'(recov_alert_o), 32'(exp_alert));
    check_value("es_idle_o", 32'(es_idle_o), 32'(exp_idle));
    es_enable_i = en;
    rng_valid_i = v;
    rng_bits_i  = bits;
    predict_cycle(en, v, bits);
  endtask

  initial begin
    bit               en;
    logic [Lanes-1:0] bits;
    es_enable_i = 1'b0;
    rng_valid_i = 1'b0;
    rng_bits_i  = '0;
    @(posedge rst_n_i);
    for (int r = 0; r < NumRows; r++) begin
      en = (Stim[r][0] != 0);
      for (int i = 0; i < Stim[r][1]; i++) begin
        make_sample(Stim[r][2], i, bits);
        drive_cycle(en, 1'b1, bits);
        repeat (Stim[r][3]) drive_cycle(en, 1'b0, Lanes'($random(seed)));
      end
    end
    // Let the last responses come out with the module off
    repeat (4) drive_cycle(1'b0, 1'b0, '0);
    $display("%0d checks, %0d mismatches", checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  // Watchdog sized from the table
  initial begin
    int total;
    int max_gap;
    int cycles;
    total   = 0;
    max_gap = 0;
    for (int r = 0; r < NumRows; r++) begin
      total = total + Stim[r][1];
      if (Stim[r][3] > max_gap) max_gap = Stim[r][3];
    end
    cycles = total * (max_gap + 1) + ResetCycles + MarginCycles;
    #(cycles * 10);
    $display("Timeout after %0d cycles, the stimulus did not complete", cycles);
    $display("Errors found");
    $finish;
  end

endmodule

//--- compile.f
logic/es_data_pkg.sv
logic/es_ctrl_pkg.sv
logic/es_main_fsm.sv
logic/es_window_timer.sv
logic/es_health_tests.sv
logic/es_packer.sv
logic/entropy_src_top.sv
tb/es_clk_gen.sv
tb/tb_entropy_src.sv

//--- Makefile
# Verilator build for the entropy source

VERILATOR ?= verilator
TOP       ?= tb_entropy_src
RTL_TOP   ?= entropy_src_top
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
TIMESCALE ?= 1ns/100ps
VFLAGS    ?= --timing --assert --timescale $(TIMESCALE)
PASS_MSG  ?= No errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
